//--- Makefile
VERILATOR  ?= verilator
TOP        := dcacheTb
RTL_TOP    := dcacheTop
FILELIST   := compile.f
OBJDIR     := obj_dir
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall
PASS_MSG   := Result: PASSED

SRCS     := $(shell grep -v '^+' $(FILELIST))
RTL_SRCS := $(shell grep -v -e '^+' -e '^dv/' $(FILELIST))
SIM      := $(OBJDIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM): $(SRCS) common/cache_consts.svh $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) +incdir+common --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJDIR)

//--- cache/cacheCtrl.sv
`include "cache_consts.svh"

module cacheCtrl import cache_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        valid_i,
  input  addr_t       addr_i,
  input  logic [1:0]  wayHit_i,
  input  logic [1:0]  wayValid_i,
  input  logic        rdDataValid_i,
  input  logic        rdLast_i,
  input  word_t       rdData_i,
  input  word_t       ramRdata0_i,
  input  word_t       ramRdata1_i,
  output logic        addrOk_o,
  output logic        dataOk_o,
  output word_t       rdData_o,
  output logic        cacheRdValid_o,
  output addr_t       cacheAddr_o,
  output logic        lookupEn_o,
  output index_t      lookupIndex_o,
  output tag_t        cmpTag_o,
  output ramAddr_t    ramAddr_o,
  output logic [1:0]  ramWe_o,
  output word_t       ramWdata_o,
  output logic        fillEn_o,
  output way_t        fillWay_o,
  output index_t      fillIndex_o,
  output tag_t        fillTag_o
);

  cacheState_e state;
  cacheState_e stateNext;

  addr_t       reqAddr;
  tag_t        reqTag;
  index_t      reqIndex;
  beat_t       reqWord;
  beat_t       beatCnt;
  way_t        victimWay;
  logic [15:0] lfsr;
  logic        lfsrFb;
  logic        cacheHit;
  logic        accept;
  logic        missStart;
  logic        beatIn;
  logic        lastBeat;
  word_t       rdDataQ;

  assign reqTag   = reqAddr[`ADDR_W-1 -: `TAG_W];
  assign reqIndex = reqAddr[`OFFSET_W +: `INDEX_W];
  assign reqWord  = reqAddr[`OFFSET_W-1 -: `WORD_SEL_W];

  assign cacheHit  = |wayHit_i;
  // a new request slips in behind a hit but never behind a miss
  assign accept    = valid_i && (state == IDLE || (state == COMPARE && cacheHit));
  assign missStart = (state == COMPARE) && !cacheHit;
  assign beatIn    = (state == REFILL) && rdDataValid_i;
  assign lastBeat  = beatIn && rdLast_i;

  always_comb begin
    stateNext = state;
    case (state)
      IDLE: begin
        if (valid_i) begin
          stateNext = COMPARE;
        end
      end
      COMPARE: begin
        if (!cacheHit) begin
          stateNext = REFILL;
        end else if (!valid_i) begin
          stateNext = IDLE;
        end
      end
      REFILL: begin
        if (lastBeat) begin
          stateNext = RESPOND;
        end
      end
      RESPOND: begin
        stateNext = IDLE;
      end
      default: begin
        stateNext = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= IDLE;
      addrOk_o <= 1'b0;
      dataOk_o <= 1'b0;
    end else begin
      state    <= stateNext;
      addrOk_o <= accept;
      dataOk_o <= (state == COMPARE && cacheHit) || lastBeat;
    end
  end

  // request latch holds from accept until the response
  always_ff @(posedge clk) begin
    if (accept) begin
      reqAddr <= addr_i;
    end
  end

  // hit word from the ram or the matching beat during refill
  always_ff @(posedge clk) begin
    if (state == COMPARE && cacheHit) begin
      rdDataQ <= wayHit_i[0] ? ramRdata0_i : ramRdata1_i;
    end else if (beatIn && beatCnt == reqWord) begin
      rdDataQ <= rdData_i;
    end
  end

  assign rdData_o = rdDataQ;

  // taps 16,14,13,11
  assign lfsrFb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt   <= '0;
      victimWay <= 1'b0;
      lfsr      <= `VICTIM_SEED;
    end else if (missStart) begin
      beatCnt <= '0;
      lfsr    <= {lfsr[14:0], lfsrFb};
      // an empty way wins over the random pick
      if (!wayValid_i[0]) begin
        victimWay <= 1'b0;
      end else if (!wayValid_i[1]) begin
        victimWay <= 1'b1;
      end else begin
        victimWay <= lfsr[0];
      end
    end else if (beatIn) begin
      beatCnt <= beatCnt + 1'b1;
    end
  end

  assign lookupEn_o    = accept;
  assign lookupIndex_o = addr_i[`OFFSET_W +: `INDEX_W];
  assign cmpTag_o      = reqTag;

  // the incoming lookup drives the ram port unless a refill owns it
  assign ramAddr_o  = (state == REFILL) ? {reqIndex, beatCnt} :
                      {addr_i[`OFFSET_W +: `INDEX_W], addr_i[`OFFSET_W-1 -: `WORD_SEL_W]};
  assign ramWe_o    = {beatIn && victimWay, beatIn && !victimWay};
  assign ramWdata_o = rdData_i;

  // tag and valid land with the last beat
  assign fillEn_o    = lastBeat;
  assign fillWay_o   = victimWay;
  assign fillIndex_o = reqIndex;
  assign fillTag_o   = reqTag;

  assign cacheRdValid_o = (state == REFILL);
  assign cacheAddr_o    = {reqAddr[`ADDR_W-1:`OFFSET_W], {`OFFSET_W{1'b0}}};

  // a response never overlaps a refill in flight
  assert property (@(posedge clk) disable iff (!rst_n)
    cacheRdValid_o |-> !dataOk_o);

  // refill address holds while the line request is open
  assert property (@(posedge clk) disable iff (!rst_n)
    cacheRdValid_o && $past(cacheRdValid_o) |-> $stable(cacheAddr_o));

  // a line lives in one way only
  assert property (@(posedge clk) disable iff (!rst_n)
    !(&wayHit_i));

endmodule

//--- cache/dataSram.sv
`include "cache_consts.svh"

module dataSram import cache_pkg::*; (
  input  logic     clk,
  input  logic     en_i,
  input  logic     we_i,
  input  ramAddr_t addr_i,
  input  word_t    wdata_i,
  output word_t    rdata_o
);

  // one word per set and word position
  localparam int Depth = 1 << (`INDEX_W + `WORD_SEL_W);

  word_t mem [Depth];

  // single port, a write cycle leaves the read data as it was
  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        mem[addr_i] <= wdata_i;
      end else begin
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule

//--- cache/tagStore.sv
`include "cache_consts.svh"

module tagStore import cache_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       lookupEn_i,
  input  index_t     lookupIndex_i,
  input  tag_t       cmpTag_i,
  input  logic       fillEn_i,
  input  way_t       fillWay_i,
  input  index_t     fillIndex_i,
  input  tag_t       fillTag_i,
  output logic [1:0] wayHit_o,
  output logic [1:0] wayValid_o
);

  localparam int Sets = 1 << `INDEX_W;

  tag_t            tagArr [2][Sets];
  logic [Sets-1:0] validArr [2];
  tag_t            tagQ [2];
  logic [1:0]      validQ;

  always_ff @(posedge clk) begin
    if (fillEn_i) begin
      tagArr[fillWay_i][fillIndex_i] <= fillTag_i;
    end
  end

  // every line starts invalid
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validArr[0] <= '0;
      validArr[1] <= '0;
    end else if (fillEn_i) begin
      validArr[fillWay_i][fillIndex_i] <= 1'b1;
    end
  end

  // lookup result shows up one cycle after the enable
  always_ff @(posedge clk) begin
    if (lookupEn_i) begin
      tagQ[0] <= tagArr[0][lookupIndex_i];
      tagQ[1] <= tagArr[1][lookupIndex_i];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validQ <= '0;
    end else if (lookupEn_i) begin
      validQ <= {validArr[1][lookupIndex_i], validArr[0][lookupIndex_i]};
    end
  end

  assign wayValid_o = validQ;

  always_comb begin
    for (int w = 0; w < 2; w++) begin
      wayHit_o[w] = validQ[w] && (tagQ[w] == cmpTag_i);
    end
  end

endmodule

//--- common/cache_consts.svh
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// pipeline and refill widths
`define ADDR_W 32
`define XLEN 64

// line geometry, 64 sets of 32-byte lines
`define OFFSET_W 5
`define INDEX_W 6
`define TAG_W 21
`define WORD_SEL_W 2
`define BEATS 4

// replacement lfsr starts here after reset
`define VICTIM_SEED 16'hACE1

`endif

//--- common/cache_pkg.sv
`include "cache_consts.svh"

package cache_pkg;

  typedef logic [`ADDR_W-1:0] addr_t;
  typedef logic [`XLEN-1:0] word_t;
  typedef logic [`TAG_W-1:0] tag_t;
  typedef logic [`INDEX_W-1:0] index_t;

  // word position inside a line
  typedef logic [$clog2(`BEATS)-1:0] beat_t;
  typedef logic way_t;

  // set index above word position
  typedef logic [`INDEX_W+`WORD_SEL_W-1:0] ramAddr_t;

  typedef enum logic [1:0] {
    IDLE,
    COMPARE,
    REFILL,
    RESPOND
  } cacheState_e;

endpackage

//--- compile.f
+incdir+common
common/cache_pkg.sv
cache/dataSram.sv
cache/tagStore.sv
cache/cacheCtrl.sv
rtl/dcacheTop.sv
dv/dcacheTb.sv

//--- dv/dcacheTb.sv
`include "cache_consts.svh"

module dcacheTb import cache_pkg::*; ();

  localparam int Dly = 5;
  localparam int Limit = 400;
  localparam logic [15:0] Seed = 16'd27653;

  logic  clk;
  logic  rst_n;
  logic  reqValid;
  addr_t reqAddr;
  logic  addrOk;
  logic  dataOk;
  word_t rdData;
  logic  refillValid;
  addr_t refillAddr;
  logic  beatValid;
  logic  beatLast;
  word_t beatData;

  logic [15:0] stimLfsr = Seed;
  logic [15:0] memLfsr = Seed;
  addr_t       expQ[$];
  int          respAt[$];
  word_t       expData = '0;
  addr_t       lastAddr = '0;
  int          cycle = 0;
  int          errCount = 0;
  int          errMark = 0;
  int          refillCount = 0;
  bit          hung = 1'b0;

  dcacheTop DUT (
    .clk            (clk),
    .rst_n          (rst_n),
    .valid_i        (reqValid),
    .addr_i         (reqAddr),
    .addrOk_o       (addrOk),
    .dataOk_o       (dataOk),
    .rdData_o       (rdData),
    .cacheRdValid_o (refillValid),
    .cacheAddr_o    (refillAddr),
    .rdDataValid_i  (beatValid),
    .rdLast_i       (beatLast),
    .rdData_i       (beatData)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // memory word holds the address in the low half and its inverse in the high half
  function automatic word_t wordPattern(input addr_t a);
    addr_t w;
    w = a & ~addr_t'(7);
    return {~w, w};
  endfunction

  function automatic addr_t lineAddr(input tag_t t, input index_t idx, input beat_t w);
    return {t, idx, w, 3'b000};
  endfunction

  // taps 16,15,13,4
  function automatic logic [15:0] lfsrStep(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[14] ^ s[12] ^ s[3]};
  endfunction

  task automatic drawBits(inout logic [15:0] st, input int n, output int v);
    v = 0;
    for (int i = 0; i < n; i++) begin
      st = lfsrStep(st);
      v = (v << 1) | {31'd0, st[0]};
    end
  endtask

  task automatic flagTimeout(input string what);
    if (!hung) begin
      $display("Timeout: %s did not arrive within %0d cycles", what, Limit);
    end
    hung = 1'b1;
  endtask

  task automatic expectTrue(input bit ok, input string what);
    assert (ok) else begin
      $display("Check failed: %s", what);
      errCount++;
    end
  endtask

  // hold the request until addrOk_o, then record it as outstanding
  task automatic readAddr(input addr_t a, input bit hold);
    int n;
    n = 0;
    reqValid = 1'b1;
    reqAddr = a;
    do begin
      @(posedge clk);
      #(Dly);
      n++;
      if (n > Limit) begin
        flagTimeout("addrOk_o");
      end
    end while (!addrOk && !hung);
    if (addrOk) begin
      expQ.push_back(a);
      lastAddr = a;
    end
    if (!hold) begin
      reqValid = 1'b0;
    end
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (expQ.size() != 0 && !hung) begin
      @(posedge clk);
      #(Dly);
      n++;
      if (n > Limit) begin
        flagTimeout("dataOk_o");
      end
    end
  endtask

  task automatic idleCycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #(Dly);
    end
  endtask

  task automatic reportTest(input int num, input string name);
    $display("test %0d %s: %0d errors", num, name, errCount - errMark);
    errMark = errCount;
  endtask

  // refill memory returns beats in word order with 0 to 2 idle cycles before each
  initial begin : memModel
    int gap;
    forever begin
      @(posedge clk);
      #(Dly);
      if (refillValid) begin
        refillCount++;
        for (int b = 0; b < `BEATS; b++) begin
          drawBits(memLfsr, 2, gap);
          idleCycles(gap % 3);
          beatValid = 1'b1;
          beatLast = (b == `BEATS - 1);
          beatData = wordPattern(refillAddr + addr_t'(8 * b));
          @(posedge clk);
          #(Dly);
          beatValid = 1'b0;
          beatLast = 1'b0;
        end
      end
    end
  end

  // oldest outstanding address sets the expected word
  always @(posedge clk) begin
    #(Dly);
    if (dataOk) begin
      if (expQ.size() == 0) begin
        $display("Unexpected: dataOk_o pulsed with no request outstanding");
        errCount++;
      end else begin
        expData = wordPattern(expQ.pop_front());
      end
      respAt.push_back(cycle);
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) dataOk |-> rdData == expData)
    else begin
      $display("Error: rdData_o is %h, expected %h", $sampled(rdData), $sampled(expData));
      errCount++;
    end

  // 32-byte lines
  assert property (@(posedge clk) disable iff (!rst_n)
    refillValid |-> refillAddr == (lastAddr & ~addr_t'(31)))
    else begin
      $display("Error: cacheAddr_o is %h, expected %h", $sampled(refillAddr),
               $sampled(lastAddr) & ~addr_t'(31));
      errCount++;
    end

  assert property (@(posedge clk) !rst_n |-> !addrOk && !dataOk && !refillValid)
    else begin
      $display("Reset failure: an output pulsed while rst_n was low");
      errCount++;
    end

  initial begin : mainSeq
    int r0;
    int base;
    int v;
    int sp;
    rst_n = 1'b0;
    reqValid = 1'b0;
    reqAddr = '0;
    beatValid = 1'b0;
    beatLast = 1'b0;
    beatData = '0;
    repeat (16) @(posedge clk);
    #(Dly);
    rst_n = 1'b1;

    expectTrue(!addrOk && !dataOk && !refillValid, "outputs not idle after reset");
    r0 = refillCount;
    readAddr(lineAddr(21'h12, 6'd3, 2'd2), 1'b0);
    drain();
    expectTrue(refillCount == r0 + 1, "first read did not raise cacheRdValid_o");
    reportTest(1, "reset and first read");

    for (int w = 0; w < 4; w++) begin
      r0 = refillCount;
      readAddr(lineAddr(tag_t'(32 + w), index_t'(10 + w), beat_t'(w)), 1'b0);
      drain();
      expectTrue(refillCount == r0 + 1, "cold miss did not refill exactly once");
    end
    reportTest(2, "cold miss per word position");

    r0 = refillCount;
    for (int w = 0; w < 4; w++) begin
      readAddr(lineAddr(21'h12, 6'd3, beat_t'(w)), 1'b0);
      drain();
    end
    expectTrue(refillCount == r0, "read of a refilled line raised cacheRdValid_o");
    reportTest(3, "hits on a refilled line");

    r0 = refillCount;
    base = respAt.size();
    for (int i = 0; i < 8; i++) begin
      readAddr(i < 4 ? lineAddr(21'h12, 6'd3, beat_t'(i)) :
               lineAddr(21'h20, 6'd10, beat_t'(i - 4)), i != 7);
    end
    drain();
    expectTrue(refillCount == r0, "streamed hits raised cacheRdValid_o");
    expectTrue(respAt.size() == base + 8 && respAt[respAt.size() - 1] - respAt[base] == 7,
               "streamed hits did not respond once per cycle");
    reportTest(4, "back-to-back hits");

    for (int round = 0; round < 5; round++) begin
      r0 = refillCount;
      for (int t = 0; t < 3; t++) begin
        readAddr(lineAddr(tag_t'(256 + t), 6'd40, beat_t'(round % 4)), 1'b0);
        drain();
      end
      // three lines cannot share two ways without a refill
      expectTrue(refillCount > r0, "three lines of one set hit without a refill");
    end
    reportTest(5, "three lines in one set");

    for (int i = 0; i < 48; i++) begin
      drawBits(stimLfsr, 13, v);
      drawBits(stimLfsr, 2, sp);
      readAddr(addr_t'(v) & ~addr_t'(7), sp == 0 && i != 47);
      idleCycles(sp);
    end
    drain();
    reportTest(6, "random reads");

    $display("tests 6, responses %0d, refills %0d, errors %0d",
             respAt.size(), refillCount, errCount);
    if (errCount == 0 && !hung) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- rtl/dcacheTop.sv
`include "cache_consts.svh"

module dcacheTop import cache_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  valid_i,
  input  addr_t addr_i,
  output logic  addrOk_o,
  output logic  dataOk_o,
  output word_t rdData_o,
  output logic  cacheRdValid_o,
  output addr_t cacheAddr_o,
  input  logic  rdDataValid_i,
  input  logic  rdLast_i,
  input  word_t rdData_i
);

  logic       lookupEn;
  index_t     lookupIndex;
  tag_t       cmpTag;
  logic [1:0] wayHit;
  logic [1:0] wayValid;
  ramAddr_t   ramAddr;
  logic [1:0] ramWe;
  word_t      ramWdata;
  word_t      ramRdata0;
  word_t      ramRdata1;
  logic       fillEn;
  way_t       fillWay;
  index_t     fillIndex;
  tag_t       fillTag;

  cacheCtrl ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .valid_i        (valid_i),
    .addr_i         (addr_i),
    .wayHit_i       (wayHit),
    .wayValid_i     (wayValid),
    .rdDataValid_i  (rdDataValid_i),
    .rdLast_i       (rdLast_i),
    .rdData_i       (rdData_i),
    .ramRdata0_i    (ramRdata0),
    .ramRdata1_i    (ramRdata1),
    .addrOk_o       (addrOk_o),
    .dataOk_o       (dataOk_o),
    .rdData_o       (rdData_o),
    .cacheRdValid_o (cacheRdValid_o),
    .cacheAddr_o    (cacheAddr_o),
    .lookupEn_o     (lookupEn),
    .lookupIndex_o  (lookupIndex),
    .cmpTag_o       (cmpTag),
    .ramAddr_o      (ramAddr),
    .ramWe_o        (ramWe),
    .ramWdata_o     (ramWdata),
    .fillEn_o       (fillEn),
    .fillWay_o      (fillWay),
    .fillIndex_o    (fillIndex),
    .fillTag_o      (fillTag)
  );

  tagStore tags (
    .clk           (clk),
    .rst_n         (rst_n),
    .lookupEn_i    (lookupEn),
    .lookupIndex_i (lookupIndex),
    .cmpTag_i      (cmpTag),
    .fillEn_i      (fillEn),
    .fillWay_i     (fillWay),
    .fillIndex_i   (fillIndex),
    .fillTag_i     (fillTag),
    .wayHit_o      (wayHit),
    .wayValid_o    (wayValid)
  );

  // both ways read on a lookup, only the victim writes on refill
  dataSram way0Ram (
    .clk     (clk),
    .en_i    (lookupEn | ramWe[0]),
    .we_i    (ramWe[0]),
    .addr_i  (ramAddr),
    .wdata_i (ramWdata),
    .rdata_o (ramRdata0)
  );

  dataSram way1Ram (
    .clk     (clk),
    .en_i    (lookupEn | ramWe[1]),
    .we_i    (ramWe[1]),
    .addr_i  (ramAddr),
    .wdata_i (ramWdata),
    .rdata_o (ramRdata1)
  );

endmodule
